//--- dv/spi_flash_ctrl_sva.sv
`include "spi_flash_cfg.svh"

module spi_flash_ctrl_sva import spi_flash_pkg::*; (
    input logic                     rst,
    input logic                     clk,
    input phy_state_t               phy_state,
    input spi_mode_t                spi_mode,
    input logic                     sck,
    input logic                     cs_n,
    input logic                     burst_done,
    input logic                     cmd_valid,
    input logic                     cmd_ready,
    input logic                     cmd_write,
    input logic [`SPI_ADDR_W-1:0]   cmd_addr,
    input logic [`SPI_LEN_W-1:0]    cmd_len,
    input logic                     wr_valid,
    input logic                     wr_ready,
    input logic [`SPI_DATA_W-1:0]   wr_data,
    input logic                     rd_valid,
    input logic                     rd_ready,
    input logic [`SPI_DATA_W-1:0]   rd_data,
    input logic                     rd_last
);
    timeunit 1ns;
    timeprecision 1ps;

    // pins parked while the phy has no burst
    assert property (@(posedge rst) disable iff (clk)
        (phy_state == PHY_IDLE) |-> (cs_n && (sck == spi_mode.cpol)))
        else $error("spi pins not parked while phy idle");

    ////////////////////
    // host handshakes
    ////////////////////

    assert property (@(posedge rst) disable iff (clk)
        (cmd_valid && !cmd_ready) |=> (cmd_valid && $stable({cmd_write, cmd_addr, cmd_len})))
        else $error("command changed while waiting for cmd_ready");

    assert property (@(posedge rst) disable iff (clk)
        (wr_valid && !wr_ready) |=> (wr_valid && $stable(wr_data)))
        else $error("write data changed while waiting for wr_ready");

    assert property (@(posedge rst) disable iff (clk)
        (rd_valid && !rd_ready) |=> (rd_valid && $stable({rd_data, rd_last})))
        else $error("read data changed while waiting for rd_ready");

    assert property (@(posedge rst) disable iff (clk)
        burst_done |-> cs_n)
        else $error("burst_done raised with cs_n low");

endmodule

bind spi_flash_ctrl spi_flash_ctrl_sva u_sva (
    .*,
    .phy_state (u_phy.state)
);

//--- dv/spi_flash_ctrl_tb.sv
`include "spi_flash_cfg.svh"

module spi_flash_ctrl_tb import spi_flash_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT  = 20000;   // clocks per wait
    localparam int NUM_ROWS = 9;

    typedef struct packed {
        logic [1:0]               mode;
        logic [`SPI_CLKDIV_W-1:0] clk_div;
        logic [`SPI_ADDR_W-1:0]   addr;
        logic [`SPI_LEN_W-1:0]    len;
        logic                     rd_stall;
        logic                     wr_stall;
        logic [`SPI_DATA_W-1:0]   data0;     // expected word i is data0 + i
    } row_t;

    logic                     rst;   // clock
    logic                     clk;   // async reset
    spi_mode_t                spi_mode;
    logic [`SPI_CLKDIV_W-1:0] clk_div;
    logic                     cmd_valid;
    logic                     cmd_ready;
    logic                     cmd_write;
    logic [`SPI_ADDR_W-1:0]   cmd_addr;
    logic [`SPI_LEN_W-1:0]    cmd_len;
    logic                     burst_done;
    logic                     wr_valid;
    logic                     wr_ready;
    logic [`SPI_DATA_W-1:0]   wr_data;
    logic                     rd_valid;
    logic                     rd_ready;
    logic [`SPI_DATA_W-1:0]   rd_data;
    logic                     rd_last;
    logic                     sck;
    logic                     cs_n;
    logic                     mosi;
    logic                     miso;

    row_t   rows [NUM_ROWS];
    integer seed        = 82690;
    int     err_cnt     = 0;
    int     chk_cnt     = 0;
    int     done_cnt    = 0;
    int     cs_fall_cnt = 0;
    logic   cs_q        = 1'b1;

    spi_flash_ctrl u_spi_flash_ctrl (.*);

    spi_flash_model u_flash (
        .sck  (sck),
        .cs_n (cs_n),
        .mosi (mosi),
        .mode (spi_mode),
        .miso (miso)
    );

    initial begin
        rst = 1'b0;
        forever #20 rst = ~rst;
    end

    // pin activity counters
    always @(posedge rst) begin
        if (burst_done) begin
            done_cnt <= done_cnt + 1;
        end
        if (cs_q && !cs_n) begin
            cs_fall_cnt <= cs_fall_cnt + 1;
        end
        cs_q <= cs_n;
    end

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_word(input string name, input rd_beat_t exp, input rd_beat_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("error %s: expected %h last %b, actual %h last %b",
                     name, exp.data, exp.last, act.data, act.last);
        end
    endtask

    task automatic check_done(input string name, input int exp, input int act);
        chk_cnt++;
        if (act != exp) begin
            err_cnt++;
            $display("error %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_period(input string name, input int exp, input int act);
        chk_cnt++;
        if (act != exp) begin
            err_cnt++;
            $display("error %s: expected %0d clocks, actual %0d clocks", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string what);
        err_cnt++;
        $display("timed out waiting for %s", what);
    endtask

    ////////////////////
    // host drivers
    ////////////////////

    task automatic issue_cmd(input logic write, input logic [`SPI_ADDR_W-1:0] addr,
                             input logic [`SPI_LEN_W-1:0] len);
        int n;
        cmd_valid = 1'b1;
        cmd_write = write;
        cmd_addr  = addr;
        cmd_len   = len;
        n = 0;
        while (!cmd_ready && n < TIMEOUT) begin
            @(negedge rst);
            n++;
        end
        if (!cmd_ready) begin
            report_timeout("cmd_ready");
        end
        @(negedge rst);   // accepted on the edge in between
        cmd_valid = 1'b0;
    endtask

    task automatic wait_done(output int cycles);
        cycles = 0;
        while (!burst_done && cycles < TIMEOUT) begin
            @(negedge rst);
            cycles++;
        end
        if (!burst_done) begin
            report_timeout("burst_done");
        end
    endtask

    task automatic drive_writes(input logic [`SPI_DATA_W-1:0] data0,
                                input logic [`SPI_LEN_W-1:0] len, input logic stall);
        int n;
        int k;
        for (int i = 0; i < int'(len); i++) begin
            if (stall) begin
                k = $random(seed) & 255;
                repeat (k) @(negedge rst);
            end
            wr_valid = 1'b1;
            wr_data  = data0 + 32'(i);
            n = 0;
            while (!wr_ready && n < TIMEOUT) begin
                @(negedge rst);
                n++;
            end
            if (!wr_ready) begin
                report_timeout("wr_ready");
            end
            @(negedge rst);
            wr_valid = 1'b0;
        end
    endtask

    task automatic collect_reads(input string name, input logic [`SPI_DATA_W-1:0] data0,
                                 input logic [`SPI_LEN_W-1:0] len, input logic stall);
        int       n;
        int       k;
        rd_beat_t exp;
        rd_beat_t act;
        for (int i = 0; i < int'(len); i++) begin
            if (stall) begin
                rd_ready = 1'b0;
                k = $random(seed) & 255;
                repeat (k) @(negedge rst);
            end
            rd_ready = 1'b1;
            n = 0;
            while (!rd_valid && n < TIMEOUT) begin
                @(negedge rst);
                n++;
            end
            if (!rd_valid) begin
                report_timeout("rd_valid");
            end
            exp.data = data0 + 32'(i);
            exp.last = (i == int'(len) - 1);
            act.data = rd_data;
            act.last = rd_last;
            check_word($sformatf("%s word %0d", name, i), exp, act);
            @(negedge rst);
        end
        rd_ready = 1'b0;
    endtask

    // clocks between the first two sck edges of the header
    task automatic measure_half_period(input string name,
                                       input logic [`SPI_CLKDIV_W-1:0] div);
        int   n;
        logic lvl;
        n = 0;
        while (cs_n && n < TIMEOUT) begin
            @(negedge rst);
            n++;
        end
        if (cs_n) begin
            report_timeout("cs_n to fall");
        end else begin
            lvl = sck;
            n   = 0;
            while (sck == lvl && n < TIMEOUT) begin
                @(negedge rst);
                n++;
            end
            lvl = sck;
            n   = 0;
            while (sck == lvl && n < TIMEOUT) begin
                @(negedge rst);
                n++;
            end
            check_period(name, int'(div) + 1, n);
        end
    endtask

    ////////////////////
    // table runner
    ////////////////////

    task automatic run_burst(input logic write, input row_t r, input string name);
        int dn0;
        int cf0;
        int cycles;
        dn0    = done_cnt;
        cf0    = cs_fall_cnt;
        cycles = 0;
        fork
            begin
                issue_cmd(write, r.addr, r.len);
                wait_done(cycles);
            end
            begin
                if (write) begin
                    drive_writes(r.data0, r.len, r.wr_stall);
                end else begin
                    collect_reads(name, r.data0, r.len, r.rd_stall);
                end
            end
            begin
                if (r.len != '0) begin
                    measure_half_period({name, " sck half period"}, r.clk_div);
                end
            end
        join
        repeat (4) @(negedge rst);
        check_done({name, " done pulses"}, 1, done_cnt - dn0);
        if (r.len == '0) begin
            check_done({name, " zero length latency"}, 2, cycles);
            check_done({name, " cs_n falls"}, 0, cs_fall_cnt - cf0);
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        r        = rows[idx];
        spi_mode = spi_mode_t'(r.mode);   // changed only while idle
        clk_div  = r.clk_div;
        run_burst(1'b1, r, $sformatf("row %0d write", idx));
        run_burst(1'b0, r, $sformatf("row %0d read", idx));
    endtask

    task automatic fill_table();
        // mode, div, addr, len, rd stall, wr stall, data0
        rows[0] = '{2'd0, 8'd1, 24'h000010, 16'd4, 1'b0, 1'b0, 32'ha500_0000};
        rows[1] = '{2'd1, 8'd1, 24'h000040, 16'd4, 1'b0, 1'b0, 32'h1111_0000};
        rows[2] = '{2'd2, 8'd1, 24'h000080, 16'd4, 1'b0, 1'b0, 32'h2222_0000};
        rows[3] = '{2'd3, 8'd1, 24'h0000c0, 16'd4, 1'b0, 1'b0, 32'h3333_0000};
        rows[4] = '{2'd0, 8'd0, 24'h000100, 16'd4, 1'b0, 1'b0, 32'h4444_0000};
        rows[5] = '{2'd3, 8'd5, 24'h000140, 16'd4, 1'b0, 1'b0, 32'h5555_0000};
        rows[6] = '{2'd1, 8'd0, 24'h000200, 16'd8, 1'b1, 1'b0, 32'h6666_0000};
        rows[7] = '{2'd2, 8'd1, 24'h000300, 16'd6, 1'b0, 1'b1, 32'h7777_0000};
        rows[8] = '{2'd0, 8'd2, 24'h000000, 16'd0, 1'b0, 1'b0, 32'h0000_0000};
    endtask

    initial begin
        clk       = 1'b1;
        spi_mode  = '0;
        clk_div   = '0;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_addr  = '0;
        cmd_len   = '0;
        wr_valid  = 1'b0;
        wr_data   = '0;
        rd_ready  = 1'b0;
        fill_table();
        repeat (2) @(posedge rst);
        @(negedge rst);
        clk = 1'b0;
        @(negedge rst);
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        $display("checks %0d, errors %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- dv/spi_flash_model.sv
`include "spi_flash_cfg.svh"

module spi_flash_model import spi_flash_pkg::*; (
    input  logic      sck,
    input  logic      cs_n,
    input  logic      mosi,
    input  spi_mode_t mode,
    output logic      miso
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [31:0] mem [256];
    logic [31:0] hdr;
    logic [31:0] wsr;
    logic        wr_op;
    logic        rd_op;
    logic [7:0]  base;     // word index of the first data word
    int          nbit;     // bits sampled since cs_n fell

    initial begin
        miso  = 1'b0;
        nbit  = 0;
        wr_op = 1'b0;
        rd_op = 1'b0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hf1a5_0000 | 32'(i);
        end
    end

    ////////////////////
    // bit level protocol
    ////////////////////

    task automatic sample_bit();
        int d;
        d = nbit - 32;
        if (nbit < 32) begin
            hdr = {hdr[30:0], mosi};
            if (nbit == 31) begin
                wr_op = (hdr[31:24] == `SPI_OP_WRITE);
                rd_op = (hdr[31:24] == `SPI_OP_READ);
                base  = hdr[9:2];   // byte address over 4
            end
        end else if (wr_op) begin
            wsr = {wsr[30:0], mosi};
            if (d % 32 == 31) begin
                mem[base + 8'(d / 32)] = wsr;
            end
        end
        nbit++;
    endtask

    task automatic drive_bit();
        int          d;
        logic [31:0] word;
        if (rd_op && nbit >= 32) begin
            d    = nbit - 32;   // next data bit the host will sample
            word = mem[base + 8'(d / 32)];
            miso = word[31 - (d % 32)];
        end
    endtask

    always @(negedge cs_n) begin
        nbit  = 0;
        wr_op = 1'b0;
        rd_op = 1'b0;
    end

    // sample on rising sck when cpol equals cpha, else on falling
    always @(sck) begin
        if (cs_n == 1'b0) begin
            if (sck == !(mode.cpol ^ mode.cpha)) begin
                sample_bit();
            end else begin
                drive_bit();
            end
        end
    end

endmodule

//--- include/spi_flash_cfg.svh
`ifndef SPI_FLASH_CFG_SVH
`define SPI_FLASH_CFG_SVH

// field widths
`define SPI_ADDR_W      24      // flash byte address
`define SPI_LEN_W       16      // burst length in words
`define SPI_DATA_W      32      // one data word
`define SPI_CLKDIV_W    8       // sck toggles every clk_div+1 clocks

// command opcodes sent in the header
`define SPI_OP_READ     8'h03
`define SPI_OP_WRITE    8'h02

// entries per word fifo
`define SPI_FIFO_DEPTH  4

`endif

//--- run_sim.sh
#!/bin/sh
# build and run the spi flash controller testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f spi_flash_ctrl.f --top-module spi_flash_ctrl_tb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vspi_flash_ctrl_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- spi_flash_ctrl.f
+incdir+include
verilog/spi_flash_pkg.sv
verilog/spi_burst_if.sv
verilog/spi_word_fifo.sv
verilog/spi_burst_seq.sv
verilog/spi_phy_io_timers.sv
verilog/spi_flash_ctrl.sv
dv/spi_flash_model.sv
dv/spi_flash_ctrl_sva.sv
dv/spi_flash_ctrl_tb.sv

//--- verilog/spi_burst_if.sv
interface spi_burst_if import spi_flash_pkg::*; ();

    logic       req_valid;  // burst offered
    logic       req_ready;  // phy can take it
    spi_burst_t req;
    logic       done;       // one pulse once cs_n is back high

    // command side
    modport seq (
        output req_valid,
        output req,
        input  req_ready,
        input  done
    );

    // pin side
    modport phy (
        input  req_valid,
        input  req,
        output req_ready,
        output done
    );

endinterface

//--- verilog/spi_burst_seq.sv
`include "spi_flash_cfg.svh"

module spi_burst_seq import spi_flash_pkg::*; (
    input  logic                     rst,
    input  logic                     clk,
    input  spi_mode_t                spi_mode,
    input  logic [`SPI_CLKDIV_W-1:0] clk_div,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic                     cmd_write,
    input  logic [`SPI_ADDR_W-1:0]   cmd_addr,
    input  logic [`SPI_LEN_W-1:0]    cmd_len,
    output logic                     burst_done,
    spi_burst_if.seq                 bus
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT
    } seq_state_t;

    seq_state_t state;
    spi_burst_t burst_live;  // command plus current config
    spi_burst_t burst_q;     // frozen for the whole burst
    logic       zero_len;

    ////////////////////
    // command capture
    ////////////////////

    always_comb begin
        burst_live.write   = cmd_write;
        burst_live.addr    = cmd_addr;
        burst_live.len     = cmd_len;
        burst_live.mode    = spi_mode;
        burst_live.clk_div = clk_div;
    end

    assign cmd_ready = (state == SEQ_IDLE);
    assign zero_len  = (burst_q.len == '0);

    always_ff @(posedge rst) begin
        if (cmd_valid && cmd_ready) begin
            burst_q <= burst_live;
        end
    end

    // while idle the phy sees live config so sck rests at the right level
    assign bus.req       = (state == SEQ_IDLE) ? burst_live : burst_q;
    assign bus.req_valid = (state == SEQ_ISSUE) && !zero_len;

    ////////////////////
    // control fsm
    ////////////////////

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state      <= SEQ_IDLE;
            burst_done <= 1'b0;
        end else begin
            burst_done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (cmd_valid) begin
                        state <= SEQ_ISSUE;
                    end
                end
                SEQ_ISSUE: begin
                    // empty burst never reaches the phy
                    if (zero_len || bus.req_ready) begin
                        state <= SEQ_WAIT;
                    end
                end
                SEQ_WAIT: begin
                    if (zero_len || bus.done) begin
                        burst_done <= 1'b1;
                        state      <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

endmodule

//--- verilog/spi_flash_ctrl.sv
`include "spi_flash_cfg.svh"

module spi_flash_ctrl import spi_flash_pkg::*; (
    input  logic                     rst,
    input  logic                     clk,
    // configuration
    input  spi_mode_t                spi_mode,
    input  logic [`SPI_CLKDIV_W-1:0] clk_div,
    // host command
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic                     cmd_write,
    input  logic [`SPI_ADDR_W-1:0]   cmd_addr,
    input  logic [`SPI_LEN_W-1:0]    cmd_len,
    output logic                     burst_done,
    // host write data
    input  logic                     wr_valid,
    output logic                     wr_ready,
    input  logic [`SPI_DATA_W-1:0]   wr_data,
    // host read data
    output logic                     rd_valid,
    input  logic                     rd_ready,
    output logic [`SPI_DATA_W-1:0]   rd_data,
    output logic                     rd_last,
    // spi pins
    output logic                     sck,
    output logic                     cs_n,
    output logic                     mosi,
    input  logic                     miso
);

    wr_beat_t wrq_data;
    logic     wrq_valid;
    logic     wrq_ready;
    rd_beat_t rdq_data;
    logic     rdq_valid;
    logic     rdq_ready;
    rd_beat_t rd_beat;

    assign rd_data = rd_beat.data;
    assign rd_last = rd_beat.last;

    spi_burst_if u_bus ();

    spi_burst_seq u_seq (
        .rst        (rst),
        .clk        (clk),
        .spi_mode   (spi_mode),
        .clk_div    (clk_div),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .cmd_write  (cmd_write),
        .cmd_addr   (cmd_addr),
        .cmd_len    (cmd_len),
        .burst_done (burst_done),
        .bus        (u_bus.seq)
    );

    spi_phy_io_timers u_phy (
        .rst       (rst),
        .clk       (clk),
        .bus       (u_bus.phy),
        .wrq_valid (wrq_valid),
        .wrq_ready (wrq_ready),
        .wrq_data  (wrq_data),
        .rdq_valid (rdq_valid),
        .rdq_ready (rdq_ready),
        .rdq_data  (rdq_data),
        .sck       (sck),
        .cs_n      (cs_n),
        .mosi      (mosi),
        .miso      (miso)
    );

    // host to phy
    spi_word_fifo #(.payload_t(wr_beat_t)) u_wr_fifo (
        .rst       (rst),
        .clk       (clk),
        .in_valid  (wr_valid),
        .in_ready  (wr_ready),
        .in_data   (wr_data),
        .out_valid (wrq_valid),
        .out_ready (wrq_ready),
        .out_data  (wrq_data)
    );

    // phy to host
    spi_word_fifo #(.payload_t(rd_beat_t)) u_rd_fifo (
        .rst       (rst),
        .clk       (clk),
        .in_valid  (rdq_valid),
        .in_ready  (rdq_ready),
        .in_data   (rdq_data),
        .out_valid (rd_valid),
        .out_ready (rd_ready),
        .out_data  (rd_beat)
    );

endmodule

//--- verilog/spi_flash_pkg.sv
`include "spi_flash_cfg.svh"

package spi_flash_pkg;

    ////////////////////
    // spi configuration
    ////////////////////

    typedef struct packed {
        logic cpol;     // sck idle level
        logic cpha;     // set when data launches on the leading edge
    } spi_mode_t;

    // one burst as handed from sequencer to phy
    typedef struct packed {
        logic                      write;   // write burst when set
        logic [`SPI_ADDR_W-1:0]    addr;    // start byte address
        logic [`SPI_LEN_W-1:0]     len;     // words
        spi_mode_t                 mode;
        logic [`SPI_CLKDIV_W-1:0]  clk_div;
    } spi_burst_t;

    ////////////////////
    // fifo payloads
    ////////////////////

    typedef logic [`SPI_DATA_W-1:0] wr_beat_t;

    typedef struct packed {
        logic [`SPI_DATA_W-1:0] data;
        logic                   last;   // final word of the burst
    } rd_beat_t;

    // phy burst states
    typedef enum logic [2:0] {
        PHY_IDLE,
        PHY_HEADER,
        PHY_DATA,
        PHY_PAUSE,
        PHY_DONE
    } phy_state_t;

endpackage

//--- verilog/spi_phy_io_timers.sv
`include "spi_flash_cfg.svh"

module spi_phy_io_timers import spi_flash_pkg::*; (
    input  logic     rst,
    input  logic     clk,
    spi_burst_if.phy bus,
    input  logic     wrq_valid,
    output logic     wrq_ready,
    input  wr_beat_t wrq_data,
    output logic     rdq_valid,
    input  logic     rdq_ready,
    output rd_beat_t rdq_data,
    output logic     sck,
    output logic     cs_n,
    output logic     mosi,
    input  logic     miso
);

    localparam int DW    = `SPI_DATA_W;
    localparam int BIT_W = $clog2(DW);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(DW - 1);

    phy_state_t               state;
    spi_burst_t               cfg;        // burst latched at accept
    logic [`SPI_CLKDIV_W-1:0] div_cnt;    // clocks left in this half period
    logic                     phase;      // 1 while sck is away from idle
    logic [BIT_W-1:0]         bit_cnt;
    logic [`SPI_LEN_W-1:0]    word_cnt;   // data words finished
    logic [DW-1:0]            mosi_sr;
    logic [DW-1:0]            miso_sr;
    logic [DW-1:0]            header;
    logic [DW-1:0]            word_in;
    logic                     rd_hold;    // completed read word not yet in fifo
    rd_beat_t                 rd_beat_q;
    logic                     done_q;

    logic tick;
    logic run;
    logic lead;
    logic trail;
    logic launch;
    logic sample;
    logic word_end;
    logic more_words;
    logic rd_word_done;
    logic stall;
    logic start_word;

    ////////////////////
    // edge decode
    ////////////////////

    assign tick   = (div_cnt == '0);
    assign run    = (state == PHY_HEADER) || (state == PHY_DATA);
    assign lead   = run && tick && !phase;
    assign trail  = run && tick && phase;
    assign launch = cfg.mode.cpha ? lead : trail;
    assign sample = cfg.mode.cpha ? trail : lead;

    assign word_end   = trail && (bit_cnt == BIT_LAST);
    assign more_words = (state == PHY_HEADER) ? (cfg.len != '0)
                                              : (word_cnt != cfg.len - 1'b1);

    assign rd_word_done = (state == PHY_DATA) && !cfg.write && sample
                          && (bit_cnt == BIT_LAST);

    // word boundary back-pressure
    always_comb begin
        if (cfg.write) begin
            stall = !wrq_valid;
        end else begin
            stall = (rd_hold || rd_word_done) && !rdq_ready;
        end
    end

    assign start_word = ((word_end && more_words) || (state == PHY_PAUSE)) && !stall;
    assign wrq_ready  = start_word && cfg.write;

    assign header  = {bus.req.write ? `SPI_OP_WRITE : `SPI_OP_READ, bus.req.addr};
    assign word_in = cfg.write ? wrq_data : '0;   // read words shift out zeros

    // idle level follows the offered config until a burst is taken
    assign sck = phase ^ ((state == PHY_IDLE) ? bus.req.mode.cpol : cfg.mode.cpol);

    assign bus.req_ready = (state == PHY_IDLE);
    assign bus.done      = done_q;
    assign rdq_valid     = rd_hold;
    assign rdq_data      = rd_beat_q;

    ////////////////////
    // burst fsm
    ////////////////////

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            state    <= PHY_IDLE;
            cs_n     <= 1'b1;
            mosi     <= 1'b0;
            phase    <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            word_cnt <= '0;
            rd_hold  <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            done_q <= 1'b0;

            case (state)
                PHY_IDLE: begin
                    if (bus.req_valid) begin
                        cs_n     <= 1'b0;
                        div_cnt  <= bus.req.clk_div;
                        phase    <= 1'b0;
                        bit_cnt  <= '0;
                        word_cnt <= '0;
                        state    <= PHY_HEADER;
                        if (!bus.req.mode.cpha) begin
                            mosi <= header[DW-1];   // first bit ahead of first edge
                        end
                    end
                end

                PHY_HEADER, PHY_DATA: begin
                    if (tick) begin
                        div_cnt <= cfg.clk_div;
                        phase   <= ~phase;
                    end else begin
                        div_cnt <= div_cnt - 1'b1;
                    end
                    if (launch && !word_end) begin
                        mosi <= mosi_sr[DW-1];
                    end
                    if (trail) begin
                        bit_cnt <= bit_cnt + 1'b1;   // wraps at the word end
                    end
                    if (word_end) begin
                        if (state == PHY_DATA) begin
                            word_cnt <= word_cnt + 1'b1;
                        end
                        if (!more_words) begin
                            state <= PHY_DONE;
                        end else if (stall) begin
                            state <= PHY_PAUSE;      // sck parked at idle, cs_n held
                        end
                    end
                end

                PHY_DONE: begin
                    if (cs_n) begin
                        done_q <= 1'b1;
                        mosi   <= 1'b0;
                        state  <= PHY_IDLE;
                    end else if (tick) begin
                        cs_n <= 1'b1;               // half period after last edge
                    end else begin
                        div_cnt <= div_cnt - 1'b1;
                    end
                end

                default: ;   // pause waits for start_word below
            endcase

            // next data word, straight after the boundary or out of pause
            if (start_word) begin
                state   <= PHY_DATA;
                div_cnt <= cfg.clk_div;
                if (!cfg.mode.cpha) begin
                    mosi <= word_in[DW-1];
                end
            end

            if (rd_hold && rdq_ready) begin
                rd_hold <= 1'b0;
            end
            if (rd_word_done) begin
                rd_hold <= 1'b1;
            end
        end
    end

    ////////////////////
    // shift registers
    ////////////////////

    always_ff @(posedge rst) begin
        if (state == PHY_IDLE && bus.req_valid) begin
            cfg     <= bus.req;
            mosi_sr <= bus.req.mode.cpha ? header : {header[DW-2:0], 1'b0};
        end else if (start_word) begin
            mosi_sr <= cfg.mode.cpha ? word_in : {word_in[DW-2:0], 1'b0};
        end else if (launch && !word_end) begin
            mosi_sr <= {mosi_sr[DW-2:0], 1'b0};
        end

        if (state == PHY_DATA && sample) begin
            miso_sr <= {miso_sr[DW-2:0], miso};
        end

        if (rd_word_done) begin
            rd_beat_q.data <= {miso_sr[DW-2:0], miso};
            rd_beat_q.last <= !more_words;
        end
    end

endmodule

//--- verilog/spi_word_fifo.sv
`include "spi_flash_cfg.svh"

module spi_word_fifo #(
    parameter type payload_t = logic [`SPI_DATA_W-1:0]
) (
    input  logic     rst,
    input  logic     clk,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    localparam int DEPTH = `SPI_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0]   FULL_CNT = (PTR_W + 1)'(DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;   // entries held
    logic             push;
    logic             pop;

    assign in_ready  = (count != FULL_CNT);
    assign out_valid = (count != '0);
    assign out_data  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge rst or posedge clk) begin
        if (clk) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push and pop together
            endcase
        end
    end

    // storage
    always_ff @(posedge rst) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule
